// ==== compile.f ====
+incdir+hw
hw/robs_pkg.sv
hw/robs_ctrl_if.sv
hw/robs_control_unit_fsm.sv
hw/robs_datapath.sv
hw/robs_multiplier.sv
testbench/robs_multiplier_tb.sv

// ==== hw/robs_control_unit_fsm.sv ====
module robs_control_unit_fsm
	import robs_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	robs_ctrl_if.ctrl    bus,
	output logic         done
);

	robs_state_t state;
	robs_state_t next_state;
	robs_ctrl_t  cw;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= st_load_m;
			done  <= 1'b0;
		end else begin
			state <= next_state;
			done  <= (next_state == st_done); // st_done never exits
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_load_m:     next_state = st_load_q;
			st_load_q:     next_state = st_clear;
			st_clear:      next_state = st_test_cnt;
			st_test_cnt:   next_state = bus.zq ? st_last_q0 : st_test_q0;
			st_test_q0:    next_state = bus.zr ? st_test_sign : st_add; // skip add on zero bit
			st_add:        next_state = st_test_sign;
			st_test_sign:  next_state = bus.zy ? st_fill_keep : st_fill_set;
			st_fill_set:   next_state = st_fill_wait;
			st_fill_wait:  next_state = st_shift;
			st_fill_keep:  next_state = st_shift;
			st_shift:      next_state = st_count;
			st_count:      next_state = st_test_cnt;
			st_last_q0:    next_state = bus.zr ? st_last_fill : st_sub; // sign bit of multiplier
			st_sub:        next_state = st_last_fill;
			st_last_fill:  next_state = st_last_shift;
			st_last_shift: next_state = st_store;
			st_store:      next_state = st_done;
			st_done:       next_state = st_done;
			default:       next_state = st_load_m;
		endcase
	end

	always_comb begin
		cw = '0;
		case (state)
			st_load_m: begin
				cw.load_m = 1'b1;
			end
			st_load_q: begin
				cw.load_q = 1'b1;
			end
			st_clear: begin
				cw.clr_a    = 1'b1;
				cw.clr_f    = 1'b1;
				cw.load_cnt = 1'b1;
			end
			st_test_q0, st_last_q0: begin
				cw.latch_q0 = 1'b1;
			end
			st_add: begin
				cw.add_m   = 1'b1;
				cw.write_a = 1'b1;
			end
			st_fill_set: begin
				cw.set_f = 1'b1;
			end
			st_fill_keep, st_last_fill: begin
				cw.keep_f = 1'b1;
			end
			st_shift, st_last_shift: begin
				cw.shift = 1'b1;
			end
			st_count: begin
				cw.dec_cnt = 1'b1;
			end
			st_sub: begin
				cw.sub_m   = 1'b1; // correction for the sign bit
				cw.write_a = 1'b1;
			end
			st_store: begin
				cw.store_p = 1'b1;
			end
			default: begin
				cw = '0;
			end
		endcase
	end

	assign bus.ctrl_word = cw;

	a_legal_state: assert property (@(posedge clk) disable iff (reset)
		state inside {st_load_m, st_load_q, st_clear, st_test_cnt, st_test_q0, st_add,
			st_test_sign, st_fill_set, st_fill_wait, st_fill_keep, st_shift, st_count,
			st_last_q0, st_sub, st_last_fill, st_last_shift, st_store, st_done})
		else $error("illegal state %b", state);

	a_done_sticky: assert property (@(posedge clk) disable iff (reset) done |=> done)
		else $error("done dropped before reset");

	a_add_sub_excl: assert property (@(posedge clk) disable iff (reset)
		!(cw.add_m && cw.sub_m))
		else $error("add and subtract requested together");

endmodule

// ==== hw/robs_ctrl_if.sv ====
interface robs_ctrl_if
	import robs_pkg::*;
();

	robs_ctrl_t ctrl_word; // strobes, decoded from state
	logic       zq;        // counter is zero
	logic       zr;        // q[0] is zero
	logic       zy;        // sign of m is zero

	// control unit side
	modport ctrl (
		output ctrl_word,
		input  zq,
		input  zr,
		input  zy
	);

	// datapath side
	modport dp (
		input  ctrl_word,
		output zq,
		output zr,
		output zy
	);

endinterface

// ==== hw/robs_datapath.sv ====
`include "robs_defs.svh"

module robs_datapath
	import robs_pkg::*;
(
	input  logic                             clk,
	input  logic                             reset,
	robs_ctrl_if.dp                          bus,
	input  logic signed [`ROBS_WIDTH-1:0]    a,
	input  logic signed [`ROBS_WIDTH-1:0]    b,
	output logic signed [2*`ROBS_WIDTH-1:0]  product
);

	localparam int W = `ROBS_WIDTH;
	localparam int CW = `ROBS_CNT_WIDTH;

	robs_ctrl_t    cw;
	logic [W-1:0]  m;      // multiplicand
	logic [W-1:0]  acc;    // accumulator, high half of product
	logic [W-1:0]  q;      // multiplier, low half of product
	logic          f;      // sign fill for acc
	logic          q0_l;
	logic          f_next;
	logic [CW-1:0] cnt;
	logic [W:0]    sum;

	assign cw = bus.ctrl_word;

	// f extends acc to W+1 bits so the sum never loses its sign
	always_comb begin
		if (cw.sub_m) begin
			sum = {f, acc} - {m[W-1], m};
		end else begin
			sum = {f, acc} + {m[W-1], m};
		end
	end

	always_ff @(posedge clk) begin
		if (cw.load_m) begin
			m <= a;
		end
	end

	always_ff @(posedge clk) begin
		if (cw.load_q) begin
			q <= b;
		end else if (cw.shift) begin
			q <= {acc[0], q[W-1:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (cw.clr_a) begin
			acc <= '0;
		end else if (cw.write_a) begin
			acc <= sum[W-1:0];
		end else if (cw.shift) begin
			acc <= {f, acc[W-1:1]}; // arithmetic shift through f
		end
	end

	always_comb begin
		f_next = f;
		if (cw.set_f) begin
			f_next = f | (m[W-1] & q0_l); // negative m added at least once
		end else if (cw.write_a && cw.sub_m) begin
			f_next = sum[W];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			f <= 1'b0;
		end else if (cw.clr_f) begin
			f <= 1'b0;
		end else if (!cw.keep_f) begin
			f <= f_next;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q0_l <= 1'b0;
			cnt  <= '0;
		end else begin
			if (cw.latch_q0) begin
				q0_l <= q[0];
			end
			if (cw.load_cnt) begin
				cnt <= CW'(W - 1);
			end else if (cw.dec_cnt) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			product <= '0;
		end else if (cw.store_p) begin
			product <= {acc, q};
		end
	end

	assign bus.zq = (cnt == '0);
	assign bus.zr = ~q[0];
	assign bus.zy = ~m[W-1];

	a_no_dec_at_zero: assert property (@(posedge clk) disable iff (reset)
		!(cw.dec_cnt && cnt == '0))
		else $error("counter decremented below zero");

endmodule

// ==== hw/robs_defs.svh ====
`ifndef ROBS_DEFS_SVH
`define ROBS_DEFS_SVH

// operand width, the product is twice this
`define ROBS_WIDTH 8

// loop counter, must hold ROBS_WIDTH-1
`define ROBS_CNT_WIDTH 3

`endif

// ==== hw/robs_multiplier.sv ====
`include "robs_defs.svh"

module robs_multiplier (
	input  logic                             clk,
	input  logic                             reset,
	input  logic signed [`ROBS_WIDTH-1:0]    a,
	input  logic signed [`ROBS_WIDTH-1:0]    b,
	output logic signed [2*`ROBS_WIDTH-1:0]  product,
	output logic                             done
);

	// control word down, status flags up
	robs_ctrl_if bus ();

	robs_control_unit_fsm i_robs_control_unit_fsm (
		.clk   (clk),
		.reset (reset),
		.bus   (bus.ctrl),
		.done  (done)
	);

	robs_datapath i_robs_datapath (
		.clk     (clk),
		.reset   (reset),
		.bus     (bus.dp),
		.a       (a),
		.b       (b),
		.product (product)
	);

endmodule

// ==== hw/robs_pkg.sv ====
package robs_pkg;

	// sparse 5-bit state encoding
	typedef enum logic [4:0] {
		st_load_m     = 5'b00000,
		st_load_q     = 5'b00001,
		st_clear      = 5'b00010,
		st_test_cnt   = 5'b00011,
		st_test_q0    = 5'b00100,
		st_add        = 5'b00101,
		st_test_sign  = 5'b00110,
		st_fill_set   = 5'b00111,
		st_fill_wait  = 5'b01000,
		st_fill_keep  = 5'b01001,
		st_shift      = 5'b01010,
		st_count      = 5'b01011,
		st_last_q0    = 5'b01100,
		st_sub        = 5'b01101,
		st_last_fill  = 5'b01111,
		st_last_shift = 5'b10010,
		st_store      = 5'b10011,
		st_done       = 5'b10100
	} robs_state_t;

	// control word with load_m in bit 0
	typedef struct packed {
		logic spare;
		logic store_p;
		logic latch_q0;
		logic dec_cnt;
		logic shift;
		logic keep_f;
		logic set_f;
		logic write_a;
		logic sub_m;
		logic add_m;
		logic load_cnt;
		logic clr_f;
		logic clr_a;
		logic load_q;
		logic load_m;
	} robs_ctrl_t;

endpackage

// ==== testbench/robs_multiplier_tb.sv ====
`include "robs_defs.svh"

module robs_multiplier_tb;

	localparam int W             = `ROBS_WIDTH;
	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 5;
	localparam int CYCLE_LIMIT   = 80;   // per multiplication after reset release
	localparam int MAX_RUNS      = 200;
	localparam int HOLD_CYCLES   = 20;
	localparam int RANDOM_RUNS   = 150;
	localparam int EARLY_CYCLES  = 20;   // well below the shortest possible run
	localparam int WATCHDOG_TIME = MAX_RUNS * CYCLE_LIMIT * CLK_PERIOD;

	logic                  clk;
	logic                  reset;
	logic signed [W-1:0]   a;
	logic signed [W-1:0]   b;
	logic signed [2*W-1:0] product;
	logic                  done;

	integer seed;
	int     error_count;
	int     check_count;
	int     test_count;
	int     failed_tests;
	int     run_count;

	robs_multiplier i_robs_multiplier (
		.clk     (clk),
		.reset   (reset),
		.a       (a),
		.b       (b),
		.product (product),
		.done    (done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// operands are widened to the product width before multiplying
	function automatic logic signed [2*W-1:0] expected_product(
		input logic signed [W-1:0] x,
		input logic signed [W-1:0] y
	);
		logic signed [2*W-1:0] xe;
		logic signed [2*W-1:0] ye;
		xe = x; // sign extends
		ye = y;
		return xe * ye;
	endfunction

	task automatic check_value(
		input string                 name,
		input logic signed [2*W-1:0] expected,
		input logic signed [2*W-1:0] actual
	);
		check_count++;
		assert (actual === expected) else begin
			error_count++;
			$display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		check_count++;
		assert (cond) else begin
			error_count++;
			$display("error: %s", what);
		end
	endtask

	// operands and reset change together on the falling edge
	task automatic start_run(input logic signed [W-1:0] x, input logic signed [W-1:0] y);
		@(negedge clk);
		a     = x;
		b     = y;
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		run_count++;
	endtask

	task automatic wait_for_done(input string name, output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < CYCLE_LIMIT) begin
			@(negedge clk);
			cycles++;
			seen = (done === 1'b1);
		end
		check_count++;
		assert (seen) else begin
			error_count++;
			$display("error: %s, done did not rise within %0d cycles", name, CYCLE_LIMIT);
		end
	endtask

	task automatic multiply_case(
		input string               test_name,
		input logic signed [W-1:0] x,
		input logic signed [W-1:0] y
	);
		string name;
		bit    seen;
		name = $sformatf("%s %0d*%0d", test_name, x, y);
		start_run(x, y);
		wait_for_done(name, seen);
		if (seen) begin
			check_value(name, expected_product(x, y), product);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic test_positive();
		int errors_before;
		errors_before = error_count;
		multiply_case("positive", 8'sd5, 8'sd7);
		multiply_case("positive", 8'sd127, 8'sd127);
		multiply_case("positive", 8'sd1, 8'sd1);
		multiply_case("positive", 8'sd12, 8'sd10);
		multiply_case("positive", 8'sd64, 8'sd2);
		multiply_case("positive", 8'sd85, 8'sd42);
		finish_test("positive", errors_before);
	endtask

	// negative multiplicand takes the fill path and negative multiplier the correction
	task automatic test_mixed_signs();
		int errors_before;
		errors_before = error_count;
		multiply_case("mixed_signs", -8'sd3, 8'sd9);
		multiply_case("mixed_signs", 8'sd9, -8'sd3);
		multiply_case("mixed_signs", -8'sd1, 8'sd100);
		multiply_case("mixed_signs", 8'sd100, -8'sd1);
		multiply_case("mixed_signs", -8'sd7, -8'sd5);
		multiply_case("mixed_signs", -8'sd128, 8'sd1);
		multiply_case("mixed_signs", 8'sd1, -8'sd128);
		multiply_case("mixed_signs", -8'sd86, 8'sd85);
		finish_test("mixed_signs", errors_before);
	endtask

	task automatic test_corners();
		int errors_before;
		errors_before = error_count;
		multiply_case("corners", -8'sd128, -8'sd128);
		multiply_case("corners", -8'sd128, 8'sd127);
		multiply_case("corners", 8'sd127, -8'sd128);
		multiply_case("corners", 8'sd0, -8'sd1);
		multiply_case("corners", -8'sd1, -8'sd1);
		multiply_case("corners", -8'sd1, 8'sd0);
		multiply_case("corners", -8'sd128, 8'sd0);
		multiply_case("corners", 8'sd0, 8'sd0);
		finish_test("corners", errors_before);
	endtask

	task automatic test_random();
		int                  errors_before;
		logic [31:0]         r;
		logic signed [W-1:0] x;
		logic signed [W-1:0] y;
		errors_before = error_count;
		for (int i = 0; i < RANDOM_RUNS; i++) begin
			r = $random(seed);
			x = r[W-1:0];
			y = r[2*W-1:W];
			multiply_case("random", x, y);
		end
		finish_test("random", errors_before);
	endtask

	// result and done hold once the run is over
	task automatic test_done_hold();
		int                    errors_before;
		bit                    seen;
		logic signed [2*W-1:0] expected;
		errors_before = error_count;
		expected      = expected_product(-8'sd77, 8'sd53);
		start_run(-8'sd77, 8'sd53);
		check_true(done === 1'b0, "done_hold: done high right after reset release");
		check_value("done_hold product after reset", '0, product);
		wait_for_done("done_hold", seen);
		if (seen) begin
			check_value("done_hold -77*53", expected, product);
			for (int i = 1; i <= HOLD_CYCLES; i++) begin
				@(negedge clk);
				check_true(done === 1'b1,
					$sformatf("done_hold: done dropped %0d cycles after the result", i));
				check_value($sformatf("done_hold product hold cycle %0d", i), expected, product);
			end
		end
		finish_test("done_hold", errors_before);
	endtask

	task automatic test_reset_mid_run();
		int errors_before;
		bit seen;
		errors_before = error_count;
		multiply_case("reset_mid_run", 8'sd33, -8'sd19);

		// a fresh reset must clear done from the previous run
		@(negedge clk);
		a     = -8'sd101;
		b     = -8'sd45;
		reset = 1'b1;
		@(negedge clk);
		check_true(done === 1'b0, "reset_mid_run: reset did not clear done");
		check_value("reset_mid_run product in reset", '0, product);
		repeat (RESET_CYCLES - 1) @(negedge clk);
		reset = 1'b0;

		repeat (EARLY_CYCLES) @(negedge clk);
		check_true(done === 1'b0, "reset_mid_run: done rose before the run could finish");

		// abort this run and check that the next one is still right
		multiply_case("reset_mid_run", 8'sd58, -8'sd113);
		start_run(-8'sd128, -8'sd3);
		repeat (EARLY_CYCLES / 2) @(negedge clk);
		start_run(8'sd121, 8'sd66);
		wait_for_done("reset_mid_run 121*66", seen);
		if (seen) begin
			check_value("reset_mid_run 121*66", expected_product(8'sd121, 8'sd66), product);
		end
		finish_test("reset_mid_run", errors_before);
	endtask

	initial begin
		reset        = 1'b1;
		a            = '0;
		b            = '0;
		seed         = 32'h1c09_fc77;
		error_count  = 0;
		check_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		run_count    = 0;

		test_positive();
		test_mixed_signs();
		test_corners();
		test_random();
		test_done_hold();
		test_reset_mid_run();

		$display("tests: %0d run, %0d failed; multiplications: %0d; checks: %0d, errors: %0d",
			test_count, failed_tests, run_count, check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// worst case budget for every run plus its reset
	initial begin
		#(WATCHDOG_TIME);
		$display("watchdog: run did not finish within %0d time units", WATCHDOG_TIME);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
